//--- verilog/fft_config.svh
`ifndef FFT_CONFIG_SVH
`define FFT_CONFIG_SVH

// Frame length, a power of two
`define FFT_N_SAMPLES 8
`define FFT_SAMPLE_W  16
`define FFT_FRAC_BITS 8

// Word address width on the bus
`define FFT_WB_ADDR_W 5

`endif

//--- verilog/fft_pkg.sv
`include "fft_config.svh"

package fft_pkg;

  typedef logic signed [`FFT_SAMPLE_W-1:0] sample_t;

  // im in the upper half, same layout as a result word on the bus
  typedef struct packed {
    sample_t im;
    sample_t re;
  } cplx_t;

  typedef sample_t [`FFT_N_SAMPLES-1:0]   real_frame_t;
  typedef cplx_t   [`FFT_N_SAMPLES-1:0]   cplx_frame_t;
  typedef cplx_t   [`FFT_N_SAMPLES/2-1:0] twiddle_row_t;

  typedef logic [$clog2($clog2(`FFT_N_SAMPLES))-1:0] stage_t;

  typedef enum logic {
    PERM_BITREV,
    PERM_STRIDE
  } perm_t;

  // One valid/ready pair between register block and core
  typedef struct packed {
    logic val;
    logic rdy;
  } core_hs_t;

endpackage

//--- verilog/fft_shuffle.sv
`timescale 1ns/1ns
`include "fft_config.svh"

module fft_shuffle #(
  parameter type            item_t = fft_pkg::sample_t,
  parameter fft_pkg::perm_t PERM   = fft_pkg::PERM_BITREV
) (
  input  item_t [`FFT_N_SAMPLES-1:0] in,
  output item_t [`FFT_N_SAMPLES-1:0] out
);
  import fft_pkg::*;

  localparam int N     = `FFT_N_SAMPLES;
  localparam int LOG_N = $clog2(N);

  function automatic int src_index(int i);
    int j;
    j = 0;
    if (PERM == PERM_BITREV) begin
      for (int b = 0; b < LOG_N; b++) begin
        j |= ((i >> b) & 1) << (LOG_N - 1 - b);
      end
    end else begin
      // Rotate left by one, even elements land in the lower half
      j = ((i << 1) | (i >> (LOG_N - 1))) & (N - 1);
    end
    return j;
  endfunction

  for (genvar i = 0; i < N; i++) begin : g_map
    assign out[i] = in[src_index(i)];
  end

endmodule

//--- verilog/fft_twiddle_rom.sv
`timescale 1ns/1ns
`include "fft_config.svh"

module fft_twiddle_rom (
  input  fft_pkg::stage_t       stage,
  output fft_pkg::twiddle_row_t row
);
  import fft_pkg::*;

  localparam int  N        = `FFT_N_SAMPLES;
  localparam int  N_STAGES = $clog2(N);
  localparam int  K_BITS   = N_STAGES - 1;
  localparam real PI       = 3.14159265358979;

  // Quarter wave, rounded to nearest
  function automatic sample_t quarter_sine(int q);
    real v;
    v = $sin(2.0 * PI * q / N) * (1 << `FFT_FRAC_BITS);
    return sample_t'($rtoi(v + 0.5));
  endfunction

  // Full period from quarter-wave symmetry
  function automatic sample_t sine_entry(int i);
    sample_t v;
    if (i <= N / 4) begin
      v = quarter_sine(i);
    end else if (i < N / 2) begin
      v = quarter_sine(N / 2 - i);
    end else if (i <= 3 * N / 4) begin
      v = -quarter_sine(i - N / 2);
    end else begin
      v = -quarter_sine(N - i);
    end
    return v;
  endfunction

  sample_t      sine_tab [N];
  twiddle_row_t rows     [N_STAGES];

  for (genvar i = 0; i < N; i++) begin : g_sine
    assign sine_tab[i] = sine_entry(i);
  end

  // Stage s keeps only the top s bits of the butterfly index
  for (genvar s = 0; s < N_STAGES; s++) begin : g_stage
    for (genvar k = 0; k < N / 2; k++) begin : g_bfly
      localparam int MASK = ((1 << s) - 1) << (K_BITS - s);
      localparam int E    = k & MASK;
      assign rows[s][k].re = sine_tab[(E + N / 4) % N];
      assign rows[s][k].im = -sine_tab[E];
    end
  end

  assign row = (stage < N_STAGES) ? rows[stage] : '0;

endmodule

//--- verilog/fft_butterfly_array.sv
`timescale 1ns/1ns
`include "fft_config.svh"

module fft_butterfly_array (
  input  fft_pkg::cplx_frame_t  in,
  input  fft_pkg::twiddle_row_t twiddles,
  output fft_pkg::cplx_frame_t  out
);
  import fft_pkg::*;

  localparam int W = `FFT_SAMPLE_W;
  localparam int F = `FFT_FRAC_BITS;

  for (genvar k = 0; k < `FFT_N_SAMPLES / 2; k++) begin : g_bfly
    cplx_t               a;
    cplx_t               b;
    cplx_t               w;
    cplx_t               bw;
    logic signed [2*W:0] prod_re;
    logic signed [2*W:0] prod_im;

    assign a = in[2*k];
    assign b = in[2*k+1];
    assign w = twiddles[k];

    // Full-width complex product b * w
    assign prod_re = b.re * w.re - b.im * w.im;
    assign prod_im = b.re * w.im + b.im * w.re;

    // Drop fraction bits, rounds toward minus infinity
    assign bw.re = prod_re[F +: W];
    assign bw.im = prod_im[F +: W];

    assign out[2*k].re   = a.re + bw.re;
    assign out[2*k].im   = a.im + bw.im;
    assign out[2*k+1].re = a.re - bw.re;
    assign out[2*k+1].im = a.im - bw.im;
  end

endmodule

//--- verilog/fft_pease_core.sv
`timescale 1ns/1ns
`include "fft_config.svh"

module fft_pease_core (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  fft_pkg::real_frame_t in_frame,
  output logic                 out_val,
  input  logic                 out_rdy,
  output fft_pkg::cplx_frame_t out_frame
);
  import fft_pkg::*;

  localparam int     N          = `FFT_N_SAMPLES;
  localparam stage_t LAST_STAGE = stage_t'($clog2(N) - 1);

  typedef enum logic [1:0] {
    IDLE,
    COMP,
    DONE
  } state_t;

  state_t       state;
  state_t       next_state;
  stage_t       stage;
  stage_t       next_stage;
  logic         accept;
  real_frame_t  rev_frame;
  cplx_frame_t  frame_q;
  cplx_frame_t  bfly_out;
  cplx_frame_t  stride_out;
  twiddle_row_t twiddles;

  fft_shuffle #(
    .item_t(sample_t),
    .PERM  (PERM_BITREV)
  ) bitrev_i (
    .in (in_frame),
    .out(rev_frame)
  );

  fft_twiddle_rom twiddle_rom_i (
    .stage(stage),
    .row  (twiddles)
  );

  fft_butterfly_array butterfly_array_i (
    .in      (frame_q),
    .twiddles(twiddles),
    .out     (bfly_out)
  );

  fft_shuffle #(
    .item_t(cplx_t),
    .PERM  (PERM_STRIDE)
  ) stride_i (
    .in (bfly_out),
    .out(stride_out)
  );

  // In DONE a new frame comes in only as the result leaves
  assign in_rdy    = (state == IDLE) || (state == DONE && out_rdy);
  assign accept    = in_val && in_rdy;
  assign out_val   = (state == DONE);
  assign out_frame = frame_q;

  always_comb begin
    next_state = state;
    next_stage = stage;
    case (state)
      IDLE: begin
        if (accept) begin
          next_state = COMP;
        end
      end
      COMP: begin
        if (stage == LAST_STAGE) begin
          next_state = DONE;
          next_stage = '0;
        end else begin
          next_stage = stage + 1'b1;
        end
      end
      DONE: begin
        if (out_rdy) begin
          next_state = accept ? COMP : IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      stage <= '0;
    end else begin
      state <= next_state;
      stage <= next_stage;
    end
  end

  // Load bit-reversed, then one butterfly pass plus stride per COMP cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      for (int i = 0; i < N; i++) begin
        frame_q[i].re <= rev_frame[i];
        frame_q[i].im <= '0;
      end
    end else if (state == COMP) begin
      frame_q <= stride_out;
    end
  end

endmodule

//--- verilog/fft_wb_regs.sv
`timescale 1ns/1ns
`include "fft_config.svh"

module fft_wb_regs (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [`FFT_WB_ADDR_W-1:0] adr,
  input  logic [31:0]               dat_w,
  output logic [31:0]               dat_r,
  output logic                      ack,
  output logic                      core_val,
  input  logic                      core_rdy,
  output fft_pkg::real_frame_t      core_frame,
  input  logic                      res_val,
  output logic                      res_rdy,
  input  fft_pkg::cplx_frame_t      res_frame
);
  import fft_pkg::*;

  localparam int                        N        = `FFT_N_SAMPLES;
  localparam int                        IDX_W    = $clog2(N);
  localparam logic [`FFT_WB_ADDR_W-1:0] CTRL_ADR = 8;
  localparam logic [`FFT_WB_ADDR_W-1:0] RES_ADR  = 16;

  real_frame_t      samples;
  cplx_frame_t      results;
  logic             busy;
  logic             done;
  logic             req;
  logic             wr_cycle;
  logic             sel_sample;
  logic             sel_ctrl;
  logic             sel_result;
  logic [IDX_W-1:0] idx;

  assign req        = cyc && stb;
  // Writes land at the end of the ack cycle
  assign wr_cycle   = req && we && ack;
  assign sel_sample = adr < CTRL_ADR;
  assign sel_ctrl   = adr == CTRL_ADR;
  assign sel_result = (adr >= RES_ADR) && (adr < RES_ADR + N);
  assign idx        = adr[IDX_W-1:0];
  assign core_frame = samples;
  assign res_rdy    = 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack   <= 1'b0;
      dat_r <= '0;
    end else begin
      ack <= req && !ack;
      if (req && !ack && !we) begin
        if (sel_ctrl) begin
          dat_r <= {30'd0, done, busy};
        end else if (sel_result) begin
          dat_r <= results[idx];
        end else begin
          dat_r <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      samples  <= '0;
      results  <= '0;
      busy     <= 1'b0;
      done     <= 1'b0;
      core_val <= 1'b0;
    end else begin
      if (wr_cycle && sel_sample) begin
        samples[idx] <= dat_w[`FFT_SAMPLE_W-1:0];
      end
      if (core_val && core_rdy) begin
        core_val <= 1'b0;
      end
      // Start is ignored while a frame is in flight
      if (wr_cycle && sel_ctrl && dat_w[0] && !busy) begin
        busy     <= 1'b1;
        done     <= 1'b0;
        core_val <= 1'b1;
      end
      if (res_val && res_rdy) begin
        results <= res_frame;
        busy    <= 1'b0;
        done    <= 1'b1;
      end
    end
  end

endmodule

//--- verilog/fft_subsystem.sv
`timescale 1ns/1ns
`include "fft_config.svh"

module fft_subsystem (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [`FFT_WB_ADDR_W-1:0] adr,
  input  logic [31:0]               dat_w,
  output logic [31:0]               dat_r,
  output logic                      ack
);
  import fft_pkg::*;

  core_hs_t    in_hs;
  core_hs_t    out_hs;
  real_frame_t in_frame;
  cplx_frame_t out_frame;

  fft_wb_regs fft_wb_regs_i (
    .clk       (clk),
    .reset     (reset),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .dat_r     (dat_r),
    .ack       (ack),
    .core_val  (in_hs.val),
    .core_rdy  (in_hs.rdy),
    .core_frame(in_frame),
    .res_val   (out_hs.val),
    .res_rdy   (out_hs.rdy),
    .res_frame (out_frame)
  );

  fft_pease_core fft_pease_core_i (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_hs.val),
    .in_rdy   (in_hs.rdy),
    .in_frame (in_frame),
    .out_val  (out_hs.val),
    .out_rdy  (out_hs.rdy),
    .out_frame(out_frame)
  );

endmodule

//--- testbench/fft_properties.sv
`timescale 1ns/1ns

module fft_properties (
  input logic                 clk,
  input logic                 reset,
  input logic                 cyc,
  input logic                 stb,
  input logic                 ack,
  input logic                 in_val,
  input logic                 in_rdy,
  input logic                 out_val,
  input logic                 out_rdy,
  input fft_pkg::cplx_frame_t out_frame
);
  int unsigned assert_failures = 0;

  ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else begin
      assert_failures++;
      $error("ack stayed high for more than one cycle");
    end

  ack_in_cycle: assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb)
    else begin
      assert_failures++;
      $error("ack raised outside a bus cycle");
    end

  // Request to the core is held until taken
  in_val_held: assert property (@(posedge clk) disable iff (reset)
    $fell(in_val) |-> $past(in_rdy))
    else begin
      assert_failures++;
      $error("in_val dropped before in_rdy");
    end

  // Result only changes when a chained frame is loaded
  out_frame_stable: assert property (@(posedge clk) disable iff (reset)
    out_val && !(out_rdy && in_val) |=> $stable(out_frame))
    else begin
      assert_failures++;
      $error("out_frame changed while the result was offered");
    end

endmodule

bind fft_subsystem fft_properties fft_properties_i (
  .clk      (clk),
  .reset    (reset),
  .cyc      (cyc),
  .stb      (stb),
  .ack      (ack),
  .in_val   (in_hs.val),
  .in_rdy   (in_hs.rdy),
  .out_val  (out_hs.val),
  .out_rdy  (out_hs.rdy),
  .out_frame(out_frame)
);

//--- testbench/tb_fft.sv
`timescale 1ns/1ns
`include "fft_config.svh"

module tb_fft;
  import fft_pkg::*;

  localparam int          N          = `FFT_N_SAMPLES;
  localparam int          N_ROWS     = 13;
  localparam int          N_FIXED    = 5;
  localparam int          TIMEOUT    = N_ROWS * 60 + 200;
  localparam int          ACK_LIMIT  = 16;
  localparam int          POLL_LIMIT = 12;
  localparam int          DONE_LIMIT = 8;
  localparam logic [31:0] SEED       = 32'h2963334d;
  localparam real         PI         = 3.14159265358979;

  typedef logic [`FFT_WB_ADDR_W-1:0] addr_t;

  localparam addr_t CTRL_ADR = 8;
  localparam addr_t RES_ADR  = 16;

  // One input frame with its spectrum, approx allows 2 LSB
  typedef struct packed {
    real_frame_t samples;
    cplx_frame_t expected;
    logic        approx;
  } vector_t;

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic        we;
  addr_t       adr;
  logic [31:0] dat_w;
  logic [31:0] dat_r;
  logic        ack;

  vector_t table_q [N_ROWS];
  int      cycles = 0;
  int      errors = 0;
  int      checks = 0;
  int      start_cycle;
  int      last_ack_cycle;
  int      total_errors;

  fft_subsystem fft_subsystem_i (
    .clk  (clk),
    .reset(reset),
    .cyc  (cyc),
    .stb  (stb),
    .we   (we),
    .adr  (adr),
    .dat_w(dat_w),
    .dat_r(dat_r),
    .ack  (ack)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Run did not finish within %0d cycles", TIMEOUT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Direct DFT, rounded to the nearest LSB
  function automatic cplx_frame_t dft(input real_frame_t x);
    cplx_frame_t y;
    sample_t     s;
    real         acc_re;
    real         acc_im;
    real         angle;
    for (int k = 0; k < N; k++) begin
      acc_re = 0.0;
      acc_im = 0.0;
      for (int n = 0; n < N; n++) begin
        s      = x[n];
        angle  = 2.0 * PI * k * n / N;
        acc_re = acc_re + $itor(s) * $cos(angle);
        acc_im = acc_im - $itor(s) * $sin(angle);
      end
      y[k].re = sample_t'($rtoi($floor(acc_re + 0.5)));
      y[k].im = sample_t'($rtoi($floor(acc_im + 0.5)));
    end
    return y;
  endfunction

  task automatic check_value(input string name, input int actual, input int expected,
                             input int tol);
    int diff;
    checks++;
    diff = actual - expected;
    if (diff > tol || diff < -tol) begin
      errors++;
      $display("ERROR at %0t ns: %s is %0d, expected %0d (tolerance %0d)",
               $time, name, actual, expected, tol);
    end
  endtask

  task automatic wb_write(input addr_t addr, input logic [31:0] data);
    int waited;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = 1'b1;
    adr    = addr;
    dat_w  = data;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ack && waited < ACK_LIMIT);
    if (!ack) begin
      errors++;
      $display("No ack from the slave for a write to address %0d at %0t ns", addr, $time);
    end else begin
      last_ack_cycle = cycles;
      // Transfer completes on the edge that samples ack
      @(negedge clk);
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_read(input addr_t addr, output logic [31:0] data);
    int waited;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = 1'b0;
    adr    = addr;
    data   = '0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ack && waited < ACK_LIMIT);
    if (!ack) begin
      errors++;
      $display("No ack from the slave for a read of address %0d at %0t ns", addr, $time);
    end else begin
      data           = dat_r;
      last_ack_cycle = cycles;
      @(negedge clk);
    end
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic load_samples(input int row);
    for (int n = 0; n < N; n++) begin
      wb_write(addr_t'(n), {16'd0, table_q[row].samples[n]});
    end
  endtask

  task automatic start_transform();
    wb_write(CTRL_ADR, 32'h1);
    start_cycle = last_ack_cycle;
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int          polls;
    status = '0;
    polls  = 0;
    while (!status[1] && polls < POLL_LIMIT) begin
      wb_read(CTRL_ADR, status);
      polls++;
    end
    if (!status[1]) begin
      errors++;
      $display("Transform not done after %0d status reads", polls);
    end else if (last_ack_cycle - start_cycle > DONE_LIMIT) begin
      errors++;
      $display("Done seen %0d cycles after the start ack, limit is %0d",
               last_ack_cycle - start_cycle, DONE_LIMIT);
    end
  endtask

  task automatic compare_results(input int row);
    logic [31:0] word;
    sample_t     got;
    sample_t     want;
    int          tol;
    tol = table_q[row].approx ? 2 : 0;
    for (int k = 0; k < N; k++) begin
      wb_read(addr_t'(RES_ADR + k), word);
      got  = word[15:0];
      want = table_q[row].expected[k].re;
      check_value($sformatf("row %0d result[%0d].re", row, k), got, want, tol);
      got  = word[31:16];
      want = table_q[row].expected[k].im;
      check_value($sformatf("row %0d result[%0d].im", row, k), got, want, tol);
    end
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    int          cos_wave [N];
    int          sin_wave [N];
    cos_wave = '{256, 181, 0, -181, -256, -181, 0, 181};
    sin_wave = '{0, 181, 256, 181, 0, -181, -256, -181};
    rnd      = SEED;
    for (int r = 0; r < N_ROWS; r++) begin
      table_q[r] = '0;
    end
    // Impulse gives a flat spectrum
    table_q[0].samples[0] = 256;
    for (int k = 0; k < N; k++) begin
      table_q[0].expected[k].re = 256;
    end
    // DC and Nyquist, 8 * 0.5 each
    for (int n = 0; n < N; n++) begin
      table_q[1].samples[n] = 128;
      table_q[2].samples[n] = (n % 2) ? -128 : 128;
      table_q[3].samples[n] = sample_t'(cos_wave[n]);
      table_q[4].samples[n] = sample_t'(sin_wave[n]);
    end
    table_q[1].expected[0].re = 1024;
    table_q[2].expected[4].re = 1024;
    // Bin 1 tone splits into N/2 at bins 1 and 7
    table_q[3].expected[1].re = 1024;
    table_q[3].expected[7].re = 1024;
    table_q[4].expected[1].im = -1024;
    table_q[4].expected[7].im = 1024;
    table_q[3].approx = 1'b1;
    table_q[4].approx = 1'b1;
    for (int r = N_FIXED; r < N_ROWS; r++) begin
      for (int n = 0; n < N; n++) begin
        rnd = xorshift(rnd);
        table_q[r].samples[n] = sample_t'($signed(rnd[8:0]));
      end
      table_q[r].expected = dft(table_q[r].samples);
      table_q[r].approx   = 1'b1;
    end
  endtask

  // Sample change and second start during a run must not reach the core
  task automatic busy_start_check();
    logic [31:0] status;
    load_samples(0);
    start_transform();
    wb_write(3, 32'h0100);
    wb_write(CTRL_ADR, 32'h1);
    wait_done();
    wb_read(CTRL_ADR, status);
    check_value("status", status, 2, 0);
    wb_read(CTRL_ADR, status);
    check_value("status", status, 2, 0);
    compare_results(0);
  endtask

  task automatic restart_check();
    logic [31:0] status;
    wb_write(3, 32'h0);
    start_transform();
    wb_read(CTRL_ADR, status);
    check_value("status", status, 1, 0);
    wait_done();
    compare_results(0);
  endtask

  initial begin
    logic [31:0] word;
    clk   = 1'b0;
    reset = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    build_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    wb_read(CTRL_ADR, word);
    check_value("status", word, 0, 0);
    for (int k = 0; k < N; k++) begin
      wb_read(addr_t'(RES_ADR + k), word);
      check_value($sformatf("result[%0d]", k), word, 0, 0);
    end

    for (int r = 0; r < N_ROWS; r++) begin
      load_samples(r);
      start_transform();
      wait_done();
      compare_results(r);
    end

    busy_start_check();
    restart_check();

    total_errors = errors + fft_subsystem_i.fft_properties_i.assert_failures;
    $display("Checks: %0d, errors: %0d", checks, total_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/fft_pkg.sv
verilog/fft_shuffle.sv
verilog/fft_twiddle_rom.sv
verilog/fft_butterfly_array.sv
verilog/fft_pease_core.sv
verilog/fft_wb_regs.sv
verilog/fft_subsystem.sv
testbench/fft_properties.sv
testbench/tb_fft.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FFT testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_fft -Mdir "$BUILD_DIR" -o tb_fft_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD_DIR"/tb_fft_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "Simulation log has no result line"
  exit 1
fi
exit 0
